// ==== sources.f ====
+incdir+include
verilog/lsu_isa_pkg.sv
verilog/lsu_bus_pkg.sv
verilog/lsq_if.sv
verilog/lane_align.sv
verilog/load_store_queue.sv
verilog/retry_timer.sv
verilog/mem_access_fsm.sv
verilog/lsu_top.sv
dv/lsu_props.sv
dv/lsu_tb.sv

// ==== Makefile ====
# Verilator build and run for the load-store unit

VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/lsu_tests.txt ====
# name op addr wdata tag waits errors exp_data exp_err (hex except waits, errors, exp_err)
# FLUSH rows flush the queue while the request with the given tag is on the bus
sw_base   SW  00000010 80f17f02 1 0 0 00000000 0
lw_base   LW  00000010 00000000 2 1 0 80f17f02 0
lb_b0     LB  00000010 00000000 3 0 0 00000002 0
lb_b1     LB  00000011 00000000 4 2 0 0000007f 0
lb_b2     LB  00000012 00000000 5 0 0 fffffff1 0
lbu_b2    LBU 00000012 00000000 6 3 0 000000f1 0
lb_b3     LB  00000013 00000000 7 0 0 ffffff80 0
lh_h0     LH  00000010 00000000 8 1 0 00007f02 0
lh_h1     LH  00000012 00000000 9 0 0 ffff80f1 0
lhu_h1    LHU 00000012 00000000 a 2 0 000080f1 0
sb_b1     SB  00000011 000000a5 b 0 0 00000000 0
sh_h1     SH  00000012 00001234 c 1 0 00000000 0
lw_merge  LW  00000010 00000000 d 0 0 1234a502 0
stall_sw  SW  00000020 cafef00d 3 30 0 00000000 0
fill_1    LW  00000020 00000000 4 0 0 cafef00d 0
fill_2    LBU 00000020 00000000 5 0 0 0000000d 0
fill_3    LB  00000023 00000000 6 0 0 ffffffca 0
fill_4    LHU 00000022 00000000 7 0 0 0000cafe 0
fill_5    LH  00000020 00000000 8 0 0 fffff00d 0
fill_6    LB  00000021 00000000 9 0 0 fffffff0 0
fill_7    LW  00000010 00000000 a 0 0 1234a502 0
fill_8    LBU 00000013 00000000 b 0 0 00000012 0
err1_sw   SW  00000030 11223344 c 1 1 00000000 0
err1_lw   LW  00000030 00000000 d 0 0 11223344 0
err3_sw   SW  00000034 deadbeef e 2 3 00000000 1
err3_lw   LW  00000034 00000000 f 0 0 6d6c6f6e 0
fl_sw     SW  00000040 a1b2c3d4 1 30 0 00000000 0
fl_lw0    LW  00000010 00000000 2 0 0 1234a502 0
fl_lw1    LW  00000020 00000000 3 0 0 cafef00d 0
flush_mid FLUSH 00000000 00000000 1 0 0 00000000 0
post_lw   LW  00000040 00000000 4 1 0 a1b2c3d4 0
post_lhu  LHU 00000010 00000000 5 0 0 0000a502 0

// ==== dv/lsu_tb.sv ====
// --------------------------------------
// LSU testbench
// File-driven requests, APB memory model
// --------------------------------------

`timescale 1ns/1ps

`include "lsu_settings.svh"

module lsu_tb
    import lsu_isa_pkg::*;
();

    localparam int MAX_REQ = 64;

    logic clk_i = 1'b0;
    logic rstn_i, flush_i, req_valid_i, req_ready_o;
    mem_op_e req_op_i;
    logic [31:0] req_addr_i, req_wdata_i, paddr_o, pwdata_o, prdata_i, resp_data_o;
    logic [3:0] req_tag_i, pstrb_o, resp_tag_o;
    lsq_ptr_t lsq_entry_o;
    logic psel_o, penable_o, pwrite_o, pready_i, pslverr_i, resp_valid_o, resp_err_o;

    // Request table, one row per non-flush test line
    string       names [MAX_REQ];
    mem_op_e     ops [MAX_REQ];
    logic [31:0] addrs [MAX_REQ], wdatas [MAX_REQ], exp_data [MAX_REQ];
    logic [3:0]  tags [MAX_REQ], flush_tag [MAX_REQ];
    int          waits [MAX_REQ], errs [MAX_REQ];
    logic        exp_err [MAX_REQ], flush_before [MAX_REQ];
    int n_req = 0, accepted = 0, exp_head = 0;
    int passed = 0, failed = 0, dropped = 0;
    int cycles = 0, limit = 0;
    bit full_seen = 0;

    lsq_ptr_t slot_exp = '0;   // Slot the next accepted request gets
    lsq_ptr_t slot_chk = '0;   // Slot owed to the last accepted request
    int slot_req = 0;          // Its request index
    int slot_cnt = 0;          // Requests accepted so far
    bit slot_due = 0;

    logic [7:0] mem [256];     // Byte image of data memory
    int xfer_idx = 0;          // Request owning the bus transfer
    int err_seen = 0;          // Errors injected on that request
    int wait_left = 0;
    int jump_idx = 0;
    bit jump_pending = 0;

    lsu_top i_dut (.*);

    always #50 clk_i = ~clk_i;

    function automatic mem_op_e op_from_name(input string s);
        case (s)
            "LB":    return LB;
            "LH":    return LH;
            "LBU":   return LBU;
            "LHU":   return LHU;
            "SB":    return SB;
            "SH":    return SH;
            "SW":    return SW;
            default: return LW;
        endcase
    endfunction

    task automatic load_tests(output bit ok);
        int fd, worst, cost;
        string line, nm, op;
        logic [31:0] a, d, t, e;
        int w, n, x;
        bit pend;
        pend = 0;
        worst = 0;
        fd = $fopen("dv/lsu_tests.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line[0] == "#") continue;
                if ($sscanf(line, "%s %s %h %h %h %d %d %h %d",
                            nm, op, a, d, t, w, n, e, x) != 9)
                    continue;
                if (op == "FLUSH") begin
                    pend = 1;
                    flush_tag[n_req] = t[3:0];
                    continue;
                end
                names[n_req] = nm;
                ops[n_req] = op_from_name(op);
                addrs[n_req] = a;
                wdatas[n_req] = d;
                tags[n_req] = t[3:0];
                waits[n_req] = w;
                errs[n_req] = n;
                exp_data[n_req] = e;
                exp_err[n_req] = (x != 0);
                flush_before[n_req] = pend;
                pend = 0;
                // Transfer time per attempt plus backoff per error
                cost = (w + 4) * (n + 1) + n * (`LSU_BACKOFF_CYCLES + 3) + 4;
                if (cost > worst) worst = cost;
                n_req++;
            end
            $fclose(fd);
            limit = worst * n_req + 200;
        end
    endtask

    task automatic send_request(input int r);
        int gap;
        gap = int'($urandom % 3);
        if (gap > 0) begin
            req_valid_i <= 1'b0;
            repeat (gap) @(posedge clk_i);
        end
        req_valid_i <= 1'b1;
        req_op_i    <= ops[r];
        req_addr_i  <= addrs[r];
        req_wdata_i <= wdatas[r];
        req_tag_i   <= tags[r];
        @(posedge clk_i);
        while (!req_ready_o) @(posedge clk_i);
        accepted++;
    endtask

    // Flush while the tagged request is in its access phase
    task automatic flush_during_transfer(input logic [3:0] tag);
        req_valid_i <= 1'b0;
        while (!(psel_o && penable_o && xfer_idx < n_req && tags[xfer_idx] == tag))
            @(posedge clk_i);
        flush_i <= 1'b1;
        @(posedge clk_i);
        flush_i <= 1'b0;
        jump_idx = accepted;
        jump_pending = 1;
        for (int i = exp_head; i < accepted; i++) begin
            $display("Dropped %s by flush", names[i]);
            dropped++;
        end
        exp_head = accepted;
    endtask

    // Reset, then every request in file order
    task automatic run_requests();
        repeat (2) @(posedge clk_i);
        rstn_i <= 1'b1;
        @(posedge clk_i);
        for (int r = 0; r < n_req; r++) begin
            if (flush_before[r]) flush_during_transfer(flush_tag[r]);
            send_request(r);
        end
        req_valid_i <= 1'b0;
        while (exp_head < n_req) @(posedge clk_i);
        repeat (5) @(posedge clk_i);
        assert (full_seen) else begin
            $display("Queue never refused a request while the memory stalled");
            failed++;
        end
    endtask

    // APB slave, wait states and error injection per request
    always @(posedge clk_i) begin
        logic [7:0] base;
        base = {paddr_o[7:2], 2'b00};
        if (rstn_i && psel_o && !penable_o) begin
            prdata_i <= {mem[base + 8'd3], mem[base + 8'd2], mem[base + 8'd1], mem[base]};
            if (waits[xfer_idx] == 0) begin
                pready_i  <= 1'b1;
                pslverr_i <= (err_seen < errs[xfer_idx]);
            end else begin
                wait_left <= waits[xfer_idx];
            end
        end else if (rstn_i && psel_o && penable_o) begin
            if (pready_i) begin
                pready_i  <= 1'b0;
                pslverr_i <= 1'b0;
                if (pslverr_i) begin
                    err_seen++;
                end else if (pwrite_o) begin
                    for (int b = 0; b < 4; b++)
                        if (pstrb_o[b]) mem[{paddr_o[7:2], 2'(b)}] = pwdata_o[8*b +: 8];
                end
                if (!pslverr_i || err_seen >= `LSU_MAX_RETRY) begin
                    err_seen = 0;
                    xfer_idx++;
                end
                if (jump_pending) begin
                    xfer_idx = jump_idx; // Flushed entries never reach the bus
                    err_seen = 0;
                    jump_pending = 0;
                end
            end else if (wait_left == 1) begin
                pready_i  <= 1'b1;
                pslverr_i <= (err_seen < errs[xfer_idx]);
            end else begin
                wait_left <= wait_left - 1;
            end
        end
    end

    // Slot index, one cycle after each accepted request
    always @(posedge clk_i) begin
        if (slot_due) begin
            assert (lsq_entry_o == slot_chk) else begin
                $display("Fail %s slot: expected %0d, actual %0d",
                         names[slot_req], slot_chk, lsq_entry_o);
                failed++;
            end
            slot_due = 0;
        end
        if (rstn_i && flush_i) slot_exp = '0; // Flush rewinds the tail
        if (rstn_i && req_valid_i && req_ready_o) begin
            slot_chk = slot_exp;
            slot_req = slot_cnt;
            slot_due = 1;
            slot_exp++;
            slot_cnt++;
        end
    end

    // Response checker, in request order
    always @(posedge clk_i) begin
        if (rstn_i && !req_ready_o && req_valid_i && !flush_i) full_seen = 1;
        if (rstn_i && resp_valid_o) begin
            assert (exp_head < accepted) else begin
                $display("Response arrived with no pending request");
                failed++;
            end
            if (exp_head < accepted) begin
                assert (resp_tag_o == tags[exp_head] && resp_data_o == exp_data[exp_head]
                        && resp_err_o == exp_err[exp_head]) begin
                    $display("Pass %s", names[exp_head]);
                    passed++;
                end else begin
                    $display("Fail %s: expected tag %h data %h err %b, actual tag %h data %h err %b",
                             names[exp_head], tags[exp_head], exp_data[exp_head],
                             exp_err[exp_head], resp_tag_o, resp_data_o, resp_err_o);
                    failed++;
                end
                exp_head++;
            end
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (limit != 0 && cycles > limit) begin
            $display("Timeout after %0d cycles with %0d of %0d requests answered",
                     cycles, exp_head, n_req);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        bit file_ok;
        rstn_i = 1'b0;
        flush_i = 1'b0;
        req_valid_i = 1'b0;
        req_op_i = LW;
        req_addr_i = '0;
        req_wdata_i = '0;
        req_tag_i = '0;
        prdata_i = '0;
        pready_i = 1'b0;
        pslverr_i = 1'b0;
        void'($urandom(32'ha5398b23));
        for (int i = 0; i < 256; i++) mem[i] = 8'(i) ^ 8'h5a;
        load_tests(file_ok);
        if (!file_ok) begin
            $display("Cannot open the test file");
            $display("Simulation failed");
        end else begin
            run_requests();
            $display("Passed %0d, failed %0d, dropped %0d", passed, failed, dropped);
            if (failed == 0) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
        end
        $finish;
    end

endmodule

// ==== dv/lsu_props.sv ====
// --------------------------------------
// LSU checks, bound into lsu_top
// APB protocol and queue admission
// --------------------------------------

`timescale 1ns/1ps

module lsu_props
    import lsu_isa_pkg::*;
(
    input logic        clk_i,
    input logic        rstn_i,
    input logic        flush_i,
    input logic        psel_i,
    input logic        penable_i,
    input logic        pwrite_i,
    input logic        pready_i,
    input logic [31:0] paddr_i,
    input logic [31:0] pwdata_i,
    input logic        resp_valid_i,
    input logic        req_valid_i,
    input logic        req_ready_i,  // Low when the queue has no free slot
    input lsq_ptr_t    entry_idx_i   // Slot of the last accepted request
);

    // PENABLE only inside a selected transfer
    a_penable_psel: assert property (@(posedge clk_i) disable iff (!rstn_i)
        penable_i |-> psel_i) else $error("PENABLE high without PSEL");

    a_stable_wait: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (psel_i && penable_i && !pready_i) |=>
            ($stable(paddr_i) && $stable(pwdata_i) && $stable(pwrite_i)))
        else $error("APB address or data changed during wait states");

    a_resp_pulse: assert property (@(posedge clk_i) disable iff (!rstn_i)
        resp_valid_i |=> !resp_valid_i) else $error("Response valid longer than one cycle");

    // A refused request gets no slot
    a_no_write_full: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (req_valid_i && !req_ready_i && !flush_i) |=> $stable(entry_idx_i))
        else $error("Queue accepted an entry while full");

endmodule

bind lsu_top lsu_props i_props (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .flush_i      (flush_i),
    .psel_i       (psel_o),
    .penable_i    (penable_o),
    .pwrite_i     (pwrite_o),
    .pready_i     (pready_i),
    .paddr_i      (paddr_o),
    .pwdata_i     (pwdata_o),
    .resp_valid_i (resp_valid_o),
    .req_valid_i  (req_valid_i),
    .req_ready_i  (req_ready_o),
    .entry_idx_i  (lsq_entry_o)
);

// ==== verilog/lsu_top.sv ====
// --------------------------------------
// Load-store unit top
// Core request port to APB data memory
// --------------------------------------

`timescale 1ns/1ps

`include "lsu_settings.svh"

module lsu_top
    import lsu_isa_pkg::*;
    import lsu_bus_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  logic                     flush_i,

    // Core requests
    input  logic                     req_valid_i,
    input  mem_op_e                  req_op_i,
    input  logic [`LSU_ADDR_W-1:0]   req_addr_i,
    input  logic [`LSU_DATA_W-1:0]   req_wdata_i,
    input  logic [`LSU_TAG_W-1:0]    req_tag_i,
    output logic                     req_ready_o,
    output lsq_ptr_t                 lsq_entry_o,   // Slot of the last accepted request

    // APB master
    output logic                     psel_o,
    output logic                     penable_o,
    output logic                     pwrite_o,
    output logic [`LSU_ADDR_W-1:0]   paddr_o,
    output logic [`LSU_DATA_W-1:0]   pwdata_o,
    output logic [`LSU_DATA_W/8-1:0] pstrb_o,
    input  logic [`LSU_DATA_W-1:0]   prdata_i,
    input  logic                     pready_i,
    input  logic                     pslverr_i,

    // Responses, one cycle pulses
    output logic                     resp_valid_o,
    output logic [`LSU_TAG_W-1:0]    resp_tag_o,
    output logic [`LSU_DATA_W-1:0]   resp_data_o,
    output logic                     resp_err_o
);

    lsq_entry_t req_entry;
    logic       full;
    logic       err_pulse;
    logic       ok_pulse;
    logic       backoff_done;
    logic       retry_exhausted;
    lsu_resp_t  resp;

    lsq_if lsq ();

    assign req_entry.op    = req_op_i;
    assign req_entry.addr  = req_addr_i;
    assign req_entry.wdata = req_wdata_i;
    assign req_entry.tag   = req_tag_i;

    assign req_ready_o = ~full;

    load_store_queue i_load_store_queue (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .flush_i     (flush_i),
        .wr_valid_i  (req_valid_i & req_ready_o), // Handshake
        .wr_entry_i  (req_entry),
        .lsq         (lsq.queue_mp),
        .full_o      (full),
        .entry_idx_o (lsq_entry_o)
    );

    mem_access_fsm i_mem_access_fsm (
        .clk_i             (clk_i),
        .rstn_i            (rstn_i),
        .flush_i           (flush_i),
        .lsq               (lsq.ctrl_mp),
        .err_pulse_o       (err_pulse),
        .ok_pulse_o        (ok_pulse),
        .backoff_done_i    (backoff_done),
        .retry_exhausted_i (retry_exhausted),
        .psel_o            (psel_o),
        .penable_o         (penable_o),
        .pwrite_o          (pwrite_o),
        .paddr_o           (paddr_o),
        .pwdata_o          (pwdata_o),
        .pstrb_o           (pstrb_o),
        .prdata_i          (prdata_i),
        .pready_i          (pready_i),
        .pslverr_i         (pslverr_i),
        .resp_valid_o      (resp_valid_o),
        .resp_o            (resp)
    );

    retry_timer i_retry_timer (
        .clk_i             (clk_i),
        .rstn_i            (rstn_i),
        .err_pulse_i       (err_pulse),
        .ok_pulse_i        (ok_pulse),
        .backoff_done_o    (backoff_done),
        .retry_exhausted_o (retry_exhausted)
    );

    assign resp_tag_o  = resp.tag;
    assign resp_data_o = resp.data;
    assign resp_err_o  = resp.err;

endmodule

// ==== verilog/mem_access_fsm.sv ====
// --------------------------------------
// APB memory controller
// Issues queue entries one at a time,
// retires them or replays after errors
// --------------------------------------

`timescale 1ns/1ps

`include "lsu_settings.svh"

module mem_access_fsm
    import lsu_isa_pkg::*;
    import lsu_bus_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  logic                    flush_i,

    lsq_if.ctrl_mp                  lsq,

    output logic                    err_pulse_o,       // Slave error, will replay
    output logic                    ok_pulse_o,        // Entry done or abandoned
    input  logic                    backoff_done_i,
    input  logic                    retry_exhausted_i, // This error is the last one

    output logic                    psel_o,
    output logic                    penable_o,
    output logic                    pwrite_o,
    output logic [`LSU_ADDR_W-1:0]  paddr_o,
    output logic [`LSU_DATA_W-1:0]  pwdata_o,
    output logic [`LSU_DATA_W/8-1:0] pstrb_o,
    input  logic [`LSU_DATA_W-1:0]  prdata_i,
    input  logic                    pready_i,
    input  logic                    pslverr_i,

    output logic                    resp_valid_o,
    output lsu_resp_t               resp_o
);

    apb_state_e             state_q;
    apb_state_e             state_d;
    lsq_entry_t             cur_q;     // Entry on the bus
    logic                   drop_q;    // Flushed while in flight
    logic                   drop;
    logic                   is_store;
    logic                   respond;   // Retire with a response
    logic [`LSU_DATA_W-1:0] load_data;

    assign drop     = drop_q | flush_i;
    assign is_store = cur_q.op inside {SB, SH, SW};

    always_comb begin
        state_d          = state_q;
        lsq.read_next    = 1'b0;
        lsq.reset_next   = 1'b0;
        lsq.advance_head = 1'b0;
        err_pulse_o      = 1'b0;
        ok_pulse_o       = 1'b0;
        respond          = 1'b0;
        case (state_q)
            IDLE: begin
                if (!lsq.empty && !flush_i) begin
                    lsq.read_next = 1'b1; // Oldest entry first
                    state_d       = SETUP;
                end
            end
            SETUP: state_d = ACCESS;
            ACCESS: begin
                if (pready_i) begin
                    state_d    = IDLE;
                    ok_pulse_o = 1'b1;
                    if (drop) begin
                        // Entry is gone, bus completes silently
                    end else if (pslverr_i && !retry_exhausted_i) begin
                        ok_pulse_o  = 1'b0;
                        err_pulse_o = 1'b1;
                        state_d     = BACKOFF;
                    end else begin
                        lsq.advance_head = 1'b1; // Success or final failure
                        respond          = 1'b1;
                    end
                end
            end
            BACKOFF: begin
                if (flush_i) begin
                    ok_pulse_o = 1'b1; // Nothing left to replay
                    state_d    = IDLE;
                end else if (backoff_done_i) begin
                    lsq.reset_next = 1'b1; // Next goes back to head
                    state_d        = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q      <= IDLE;
            drop_q       <= 1'b0;
            resp_valid_o <= 1'b0;
        end else begin
            state_q      <= state_d;
            resp_valid_o <= respond;
            if (state_d == IDLE) begin
                drop_q <= 1'b0;
            end else if (flush_i) begin
                drop_q <= 1'b1;
            end
        end
    end

    // Payload, no reset
    always_ff @(posedge clk_i) begin
        if (lsq.read_next) begin
            cur_q <= lsq.entry;
        end
        if (respond) begin
            resp_o.tag  <= cur_q.tag;
            resp_o.err  <= pslverr_i;
            resp_o.data <= (is_store || pslverr_i) ? '0 : load_data;
        end
    end

    assign psel_o    = (state_q == SETUP) || (state_q == ACCESS);
    assign penable_o = (state_q == ACCESS);
    assign pwrite_o  = is_store;
    assign paddr_o   = {cur_q.addr[`LSU_ADDR_W-1:2], 2'b00}; // Word aligned, lanes via strobe

    lane_align i_lane_align (
        .op_i        (cur_q.op),
        .addr_lo_i   (cur_q.addr[1:0]),
        .wdata_i     (cur_q.wdata),
        .rdata_i     (prdata_i),
        .pwdata_o    (pwdata_o),
        .pstrb_o     (pstrb_o),
        .load_data_o (load_data)
    );

endmodule

// ==== verilog/retry_timer.sv ====
// --------------------------------------
// Retry timer
// Backoff countdown and error counter
// --------------------------------------

`timescale 1ns/1ps

`include "lsu_settings.svh"

module retry_timer (
    input  logic clk_i,
    input  logic rstn_i,
    input  logic err_pulse_i,       // Slave error on the current entry
    input  logic ok_pulse_i,        // Entry finished, start over
    output logic backoff_done_o,    // Last backoff cycle
    output logic retry_exhausted_o  // Next error retires the entry
);

    localparam int CNT_W = $clog2(`LSU_BACKOFF_CYCLES + 1);
    localparam int ERR_W = $clog2(`LSU_MAX_RETRY + 1);

    logic [CNT_W-1:0] cnt_q;     // Backoff cycles left
    logic [ERR_W-1:0] err_cnt_q; // Consecutive errors

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cnt_q     <= '0;
            err_cnt_q <= '0;
        end else if (err_pulse_i) begin
            cnt_q     <= CNT_W'(`LSU_BACKOFF_CYCLES);
            err_cnt_q <= err_cnt_q + ERR_W'(1);
        end else if (ok_pulse_i) begin
            cnt_q     <= '0;
            err_cnt_q <= '0;
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - CNT_W'(1);
        end
    end

    // Countdown starts in the first backoff cycle
    assign backoff_done_o = (cnt_q == CNT_W'(1));

    assign retry_exhausted_o = (err_cnt_q == ERR_W'(`LSU_MAX_RETRY - 1));

endmodule

// ==== verilog/load_store_queue.sv ====
// --------------------------------------
// Load-store queue
// Circular buffer, tail writes, next issues
// and head retires, with replay and flush
// --------------------------------------

`timescale 1ns/1ps

`include "lsu_settings.svh"

module load_store_queue
    import lsu_isa_pkg::*;
(
    input  logic       clk_i,
    input  logic       rstn_i,
    input  logic       flush_i,      // Drop every entry

    input  logic       wr_valid_i,   // New entry at tail
    input  lsq_entry_t wr_entry_i,

    lsq_if.queue_mp    lsq,

    output logic       full_o,       // No room, also during flush and reset
    output lsq_ptr_t   entry_idx_o   // Index given to the last write
);

    // Counts need one bit more than the pointers
    localparam int CNT_W = $clog2(`LSU_LSQ_ENTRIES) + 1;

    lsq_entry_t       entry_mem [`LSU_LSQ_ENTRIES];

    lsq_ptr_t         head_q;        // Oldest unretired entry
    lsq_ptr_t         next_q;        // Next entry to issue
    lsq_ptr_t         tail_q;        // Next free slot
    logic [CNT_W-1:0] num_q;         // Entries not yet retired
    logic [CNT_W-1:0] num_to_read_q; // Entries not yet issued

    logic             wr_en;
    logic             rd_en;
    logic             adv_en;

    // Write only with a free slot
    assign wr_en  = wr_valid_i & ~flush_i & (num_q < CNT_W'(`LSU_LSQ_ENTRIES));
    // Issue only what is stored, never during a replay
    assign rd_en  = lsq.read_next & (num_to_read_q != '0) & ~lsq.reset_next;
    assign adv_en = lsq.advance_head & (num_q != '0) & ~lsq.reset_next;

    // Entry storage
    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            entry_mem[tail_q] <= wr_entry_i;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q        <= '0;
            next_q        <= '0;
            tail_q        <= '0;
            num_q         <= '0;
            num_to_read_q <= '0;
            entry_idx_o   <= '0;
        end else if (flush_i) begin
            head_q        <= '0;
            next_q        <= '0;
            tail_q        <= '0;
            num_q         <= '0;
            num_to_read_q <= '0;
            entry_idx_o   <= '0;
        end else if (lsq.reset_next) begin
            // Replay from head, a write still lands
            if (wr_en) begin
                entry_idx_o <= tail_q;
            end
            next_q        <= head_q;
            tail_q        <= tail_q + lsq_ptr_t'(wr_en);
            num_q         <= num_q + CNT_W'(wr_en);
            num_to_read_q <= num_q + CNT_W'(wr_en); // All unretired entries again
        end else begin
            if (wr_en) begin
                entry_idx_o <= tail_q; // Slot of this write
            end
            next_q        <= next_q + lsq_ptr_t'(rd_en);
            head_q        <= head_q + lsq_ptr_t'(adv_en);
            tail_q        <= tail_q + lsq_ptr_t'(wr_en);
            num_q         <= num_q + CNT_W'(wr_en) - CNT_W'(adv_en);
            num_to_read_q <= num_to_read_q + CNT_W'(wr_en) - CNT_W'(rd_en);
        end
    end

    // Entry at next is visible in the read cycle
    assign lsq.entry = entry_mem[next_q];
    assign lsq.empty = (num_to_read_q == '0);

    assign full_o = (num_q == CNT_W'(`LSU_LSQ_ENTRIES)) | flush_i | ~rstn_i;

endmodule

// ==== verilog/lane_align.sv ====
// --------------------------------------
// Lane aligner
// Store lanes and strobes, load extension
// --------------------------------------

`timescale 1ns/1ps

`include "lsu_settings.svh"

module lane_align
    import lsu_isa_pkg::*;
(
    input  mem_op_e                  op_i,
    input  logic [1:0]               addr_lo_i,   // Byte offset in the word
    input  logic [`LSU_DATA_W-1:0]   wdata_i,     // Store data, low aligned
    input  logic [`LSU_DATA_W-1:0]   rdata_i,     // Raw bus word
    output logic [`LSU_DATA_W-1:0]   pwdata_o,
    output logic [`LSU_DATA_W/8-1:0] pstrb_o,
    output logic [`LSU_DATA_W-1:0]   load_data_o
);

    localparam int DW = `LSU_DATA_W;

    logic [DW-1:0] lane; // Addressed lane moved to bit 0

    assign lane = rdata_i >> {addr_lo_i, 3'b000};

    always_comb begin
        pwdata_o = wdata_i;
        pstrb_o  = '0; // Reads carry no strobe
        case (op_i)
            SB: begin
                pwdata_o = {(DW/8){wdata_i[7:0]}};  // Byte in every lane
                pstrb_o  = (DW/8)'(1) << addr_lo_i;
            end
            SH: begin
                pwdata_o = {(DW/16){wdata_i[15:0]}};
                pstrb_o  = (DW/8)'(2'b11) << {addr_lo_i[1], 1'b0};
            end
            SW:      pstrb_o = '1;
            default: pstrb_o = '0;
        endcase
    end

    always_comb begin
        case (op_i)
            LB:      load_data_o = {{(DW-8){lane[7]}}, lane[7:0]};
            LBU:     load_data_o = {{(DW-8){1'b0}}, lane[7:0]};
            LH:      load_data_o = {{(DW-16){lane[15]}}, lane[15:0]};
            LHU:     load_data_o = {{(DW-16){1'b0}}, lane[15:0]};
            default: load_data_o = rdata_i; // Word, or unused for stores
        endcase
    end

endmodule

// ==== verilog/lsq_if.sv ====
// --------------------------------------
// Queue to controller link
// --------------------------------------

`timescale 1ns/1ps

interface lsq_if
    import lsu_isa_pkg::*;
();

    logic       read_next;    // Take the entry at next
    logic       reset_next;   // Replay, rewind next to head
    logic       advance_head; // Retire the head entry
    lsq_entry_t entry;        // Entry at next, same cycle as read
    logic       empty;        // Nothing left to issue

    // Storage side
    modport queue_mp (
        input  read_next,
        input  reset_next,
        input  advance_head,
        output entry,
        output empty
    );

    // Issue side
    modport ctrl_mp (
        output read_next,
        output reset_next,
        output advance_head,
        input  entry,
        input  empty
    );

endinterface

// ==== verilog/lsu_bus_pkg.sv ====
// --------------------------------------
// LSU bus package
// APB master states and core responses
// --------------------------------------

`include "lsu_settings.svh"

package lsu_bus_pkg;

    // APB master phases, plus the wait before a replay
    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS,
        BACKOFF
    } apb_state_e;

    // Response to the core
    typedef struct packed {
        logic [`LSU_TAG_W-1:0]  tag;  // Tag of the retired entry
        logic [`LSU_DATA_W-1:0] data; // Extended load data
        logic                   err;  // Failed after all retries
    } lsu_resp_t;

endpackage

// ==== verilog/lsu_isa_pkg.sv ====
// --------------------------------------
// LSU ISA package
// Memory opcodes and queue entry layout
// --------------------------------------

`include "lsu_settings.svh"

package lsu_isa_pkg;

    // Loads first, stores in the upper half
    typedef enum logic [2:0] {
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW
    } mem_op_e;

    // One decoded memory operation
    typedef struct packed {
        mem_op_e                op;    // Width, sign and direction
        logic [`LSU_ADDR_W-1:0] addr;  // Byte address
        logic [`LSU_DATA_W-1:0] wdata; // Store data, low aligned
        logic [`LSU_TAG_W-1:0]  tag;   // Returned with the response
    } lsq_entry_t;

    // Index into the circular queue
    typedef logic [$clog2(`LSU_LSQ_ENTRIES)-1:0] lsq_ptr_t;

endpackage

// ==== include/lsu_settings.svh ====
// --------------------------------------
// LSU settings
// Queue depth, bus widths and retry timing
// --------------------------------------

`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// Queue depth, keep it a power of two
`define LSU_LSQ_ENTRIES 8

`define LSU_ADDR_W 32 // Byte address
`define LSU_DATA_W 32 // APB data bus
`define LSU_TAG_W  4  // Core request tag

// Idle cycles between a slave error and the replay
`define LSU_BACKOFF_CYCLES 4
`define LSU_MAX_RETRY      3 // Errors before the entry fails

`endif
